/* hdl/mem_pkg.sv */
package mem_pkg;

  // Byte address as seen by the core.
  typedef logic [31:0] addr_t;

  // One cache line is one word.
  typedef logic [31:0] word_t;

  // Byte offset inside a line, not used for lookup.
  localparam int OFFSET_BITS = 2;

endpackage

/* hdl/cache_pkg.sv */
package cache_pkg;

  // Tag RAM entry. Only the bits above offset and index get compared.
  typedef struct packed {
    logic           valid;
    mem_pkg::addr_t tag;
  } tag_entry_t;

  // Result of one bank lookup.
  typedef struct packed {
    logic           hit;
    mem_pkg::word_t data;
  } bank_rsp_t;

endpackage

/* hdl/bank_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bank_req_if;
  import mem_pkg::*;

  logic  req_valid;
  logic  req_ready;
  addr_t addr;
  logic  fill_valid;
  addr_t fill_addr;
  word_t fill_data;

  modport router (
    output req_valid, addr, fill_valid, fill_addr, fill_data,
    input  req_ready
  );

  modport bank (
    input  req_valid, addr, fill_valid, fill_addr, fill_data,
    output req_ready
  );
endinterface

interface bank_rsp_if;
  import mem_pkg::*;

  logic  rsp_valid;
  logic  rsp_ready;
  logic  hit;
  word_t data;

  modport bank (
    output rsp_valid, hit, data,
    input  rsp_ready
  );

  modport collector (
    input  rsp_valid, hit, data,
    output rsp_ready
  );
endinterface

`default_nettype wire

/* hdl/bram.sv */
`timescale 1ns/1ps
`default_nettype none

module bram #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 64
)(
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic                     wen,
  input  entry_t                   din,
  output entry_t                   dout
);

  entry_t mem [DEPTH];

  // Read port holds its last value during a write.
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[addr] <= din;
    end else begin
      dout <= mem[addr];
    end
  end

  a_wr_addr_known: assert property (
    @(posedge clk) wen |-> !$isunknown(addr)
  );

endmodule

`default_nettype wire

/* hdl/direct_map.sv */
`timescale 1ns/1ps
`default_nettype none

module direct_map #(
  parameter int NUM_BANKS     = 4,
  parameter int SETS_PER_BANK = 64
)(
  input  logic     clk,
  input  logic     rst,
  bank_req_if.bank req,
  bank_rsp_if.bank rsp
);
  import mem_pkg::*;
  import cache_pkg::*;

  localparam int BANK_BITS = $clog2(NUM_BANKS);
  localparam int SET_BITS  = $clog2(SETS_PER_BANK);
  localparam int TAG_LSB   = OFFSET_BITS + BANK_BITS + SET_BITS;
  localparam int ADDR_MSB  = $bits(addr_t) - 1;

  logic [SET_BITS-1:0]      req_set;
  logic [SET_BITS-1:0]      fill_set;
  logic [SET_BITS-1:0]      ram_addr;
  logic [SETS_PER_BANK-1:0] valid_q;
  logic                     valid_rd_q;
  logic                     inflight_q;
  addr_t                    req_tag_q;
  word_t                    data_out;
  tag_entry_t               tag_in;
  tag_entry_t               tag_out;
  bank_rsp_t                slot_q;
  logic                     slot_valid_q;
  logic                     accept;
  logic                     drain;
  logic                     busy;
  logic                     tag_match;
  logic                     hit;

  // Bank bits sit between offset and set index.
  assign req_set  = req.addr[OFFSET_BITS + BANK_BITS +: SET_BITS];
  assign fill_set = req.fill_addr[OFFSET_BITS + BANK_BITS +: SET_BITS];
  assign ram_addr = req.fill_valid ? fill_set : req_set; // Fill owns the port.

  assign tag_in = '{valid: 1'b1, tag: req.fill_addr};

  bram #(
    .entry_t(word_t),
    .DEPTH  (SETS_PER_BANK)
  ) cached_data (
    .clk,
    .addr(ram_addr),
    .wen (req.fill_valid),
    .din (req.fill_data),
    .dout(data_out)
  );

  bram #(
    .entry_t(tag_entry_t),
    .DEPTH  (SETS_PER_BANK)
  ) valid_and_tag (
    .clk,
    .addr(ram_addr),
    .wen (req.fill_valid),
    .din (tag_in),
    .dout(tag_out)
  );

  assign drain  = slot_valid_q && rsp.rsp_ready;
  assign busy   = inflight_q || (slot_valid_q && !drain); // Slot must be free next edge.
  assign accept = req.req_valid && req.req_ready;

  assign req.req_ready = !req.fill_valid && !busy;

  assign tag_match = tag_out.tag[ADDR_MSB:TAG_LSB] == req_tag_q[ADDR_MSB:TAG_LSB];
  assign hit       = valid_rd_q && tag_out.valid && tag_match;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q      <= '0;
      inflight_q   <= 1'b0;
      slot_valid_q <= 1'b0;
    end else begin
      if (req.fill_valid) begin
        valid_q[fill_set] <= 1'b1;
      end
      inflight_q <= accept;
      if (inflight_q) begin
        slot_valid_q <= 1'b1;
      end else if (drain) begin
        slot_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_tag_q  <= req.addr;
      valid_rd_q <= valid_q[req_set]; // Sampled with the RAM read.
    end
    if (inflight_q) begin
      slot_q <= '{hit: hit, data: data_out};
    end
  end

  assign rsp.rsp_valid = slot_valid_q;
  assign rsp.hit       = slot_q.hit;
  assign rsp.data      = slot_q.data;

  a_no_read_on_fill: assert property (
    @(posedge clk) disable iff (rst) !(accept && req.fill_valid)
  );

endmodule

`default_nettype wire

/* hdl/bank_router.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_router #(
  parameter int NUM_BANKS = 4
)(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         req_valid,
  input  mem_pkg::addr_t               req_addr,
  output logic                         req_ready,
  input  logic                         fill_valid,
  input  mem_pkg::addr_t               fill_addr,
  input  mem_pkg::word_t               fill_data,
  bank_req_if.router                   bank [NUM_BANKS],
  output logic                         order_valid,
  output logic [$clog2(NUM_BANKS)-1:0] order_bank,
  input  logic                         order_ready
);
  import mem_pkg::*;

  localparam int BANK_BITS = $clog2(NUM_BANKS);

  logic [BANK_BITS-1:0] req_bank;
  logic [BANK_BITS-1:0] fill_bank;
  logic [NUM_BANKS-1:0] bank_ready;
  logic [NUM_BANKS-1:0] bank_take;

  assign req_bank  = req_addr[OFFSET_BITS +: BANK_BITS];
  assign fill_bank = fill_addr[OFFSET_BITS +: BANK_BITS];

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    // Valid only with room in the order FIFO.
    assign bank[b].req_valid  = req_valid && order_ready && (req_bank == BANK_BITS'(b));
    assign bank[b].addr       = req_addr;
    assign bank[b].fill_valid = fill_valid && (fill_bank == BANK_BITS'(b));
    assign bank[b].fill_addr  = fill_addr;
    assign bank[b].fill_data  = fill_data;

    assign bank_ready[b] = bank[b].req_ready;
    assign bank_take[b]  = bank[b].req_valid && bank[b].req_ready;
  end

  // Push and bank transfer share the edge.
  assign order_valid = req_valid && bank_ready[req_bank];
  assign order_bank  = req_bank;

  assign req_ready = order_ready && bank_ready[req_bank];

  a_one_bank_per_cycle: assert property (
    @(posedge clk) disable iff (rst) $onehot0(bank_take)
  );

endmodule

`default_nettype wire

/* hdl/rsp_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module rsp_collector #(
  parameter int NUM_BANKS   = 4,
  parameter int ORDER_DEPTH = 4
)(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         order_valid,
  input  logic [$clog2(NUM_BANKS)-1:0] order_bank,
  output logic                         order_ready,
  bank_rsp_if.collector                bank [NUM_BANKS],
  output logic                         rsp_valid,
  output logic                         rsp_hit,
  output mem_pkg::word_t               rsp_data,
  input  logic                         rsp_ready
);
  import cache_pkg::*;

  localparam int BANK_BITS = $clog2(NUM_BANKS);
  localparam int PTR_BITS  = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
  localparam int CNT_BITS  = $clog2(ORDER_DEPTH + 1);

  logic [BANK_BITS-1:0] order_q [ORDER_DEPTH];
  logic [PTR_BITS-1:0]  wr_ptr_q;
  logic [PTR_BITS-1:0]  rd_ptr_q;
  logic [CNT_BITS-1:0]  count_q;
  logic [BANK_BITS-1:0] head_bank;
  logic [NUM_BANKS-1:0] bank_valid;
  bank_rsp_t            bank_rsp [NUM_BANKS];
  bank_rsp_t            head_rsp;
  logic                 fifo_empty;
  logic                 push;
  logic                 pop;

  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_BITS'(ORDER_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign fifo_empty  = count_q == '0;
  assign order_ready = count_q != CNT_BITS'(ORDER_DEPTH);
  assign push        = order_valid && order_ready;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    assign bank_valid[b] = bank[b].rsp_valid;
    assign bank_rsp[b]   = '{hit: bank[b].hit, data: bank[b].data};
    assign bank[b].rsp_ready = pop && (head_bank == BANK_BITS'(b)); // Head bank only.
  end

  // Head bank drives the outputs directly.
  assign head_bank = order_q[rd_ptr_q];
  assign head_rsp  = bank_rsp[head_bank];
  assign rsp_valid = !fifo_empty && bank_valid[head_bank];
  assign rsp_hit   = head_rsp.hit;
  assign rsp_data  = head_rsp.data;
  assign pop       = rsp_valid && rsp_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      order_q[wr_ptr_q] <= order_bank;
    end
  end

  // Every bank response must have been ordered by the router.
  a_no_orphan_rsp: assert property (
    @(posedge clk) disable iff (rst) fifo_empty |-> !(|bank_valid)
  );

endmodule

`default_nettype wire

/* hdl/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
  parameter int NUM_BANKS     = 4,
  parameter int SETS_PER_BANK = 64,
  parameter int ORDER_DEPTH   = 4
)(
  input  logic           clk,
  input  logic           rst,

  input  logic           req_valid,
  input  mem_pkg::addr_t req_addr,
  output logic           req_ready,

  input  logic           fill_valid,
  input  mem_pkg::addr_t fill_addr,
  input  mem_pkg::word_t fill_data,

  output logic           rsp_valid,
  output logic           rsp_hit,
  output mem_pkg::word_t rsp_data,
  input  logic           rsp_ready
);

  localparam int BANK_BITS = $clog2(NUM_BANKS);

  logic                 order_valid;
  logic [BANK_BITS-1:0] order_bank;
  logic                 order_ready;

  bank_req_if req_bus [NUM_BANKS] ();
  bank_rsp_if rsp_bus [NUM_BANKS] ();

  bank_router #(
    .NUM_BANKS(NUM_BANKS)
  ) u_bank_router (
    .clk,
    .rst,
    .req_valid,
    .req_addr,
    .req_ready,
    .fill_valid,
    .fill_addr,
    .fill_data,
    .bank       (req_bus),
    .order_valid,
    .order_bank,
    .order_ready
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    direct_map #(
      .NUM_BANKS    (NUM_BANKS),
      .SETS_PER_BANK(SETS_PER_BANK)
    ) u_direct_map (
      .clk,
      .rst,
      .req(req_bus[b]),
      .rsp(rsp_bus[b])
    );
  end

  rsp_collector #(
    .NUM_BANKS  (NUM_BANKS),
    .ORDER_DEPTH(ORDER_DEPTH)
  ) u_rsp_collector (
    .clk,
    .rst,
    .order_valid,
    .order_bank,
    .order_ready,
    .bank       (rsp_bus),
    .rsp_valid,
    .rsp_hit,
    .rsp_data,
    .rsp_ready
  );

endmodule

`default_nettype wire

/* test/tb_cache_top.sv */
`timescale 1ns/1ps

module tb_cache_top;
  import mem_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int NUM_TESTS   = 6;
  localparam int NUM_ENTRIES = 34;

  localparam logic [1:0] OP_READ = 2'd0;
  localparam logic [1:0] OP_FILL = 2'd1;
  localparam logic [1:0] OP_RST  = 2'd2;

  typedef struct packed {
    logic [2:0] test;
    logic [1:0] op;
    addr_t      addr;
    word_t      fill;
    logic       hit;
    word_t      data;
  } entry_t;

  // Bank is addr[3:2], set is addr[9:4], tag is addr[31:10].
  localparam entry_t STIM [NUM_ENTRIES] = '{
    '{3'd0, OP_READ, 32'h0000_0000, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{3'd0, OP_READ, 32'h1234_5678, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{3'd0, OP_READ, 32'hffff_fffc, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{3'd1, OP_FILL, 32'h0000_0100, 32'ha0a0_0001, 1'b0, 32'h0000_0000},
    '{3'd1, OP_FILL, 32'h0000_0204, 32'hb0b0_0002, 1'b0, 32'h0000_0000},
    '{3'd1, OP_FILL, 32'h8000_0058, 32'hc0c0_0003, 1'b0, 32'h0000_0000},
    '{3'd1, OP_READ, 32'h0000_0100, 32'h0000_0000, 1'b1, 32'ha0a0_0001},
    '{3'd1, OP_READ, 32'h0000_0103, 32'h0000_0000, 1'b1, 32'ha0a0_0001},
    '{3'd1, OP_READ, 32'h8000_005a, 32'h0000_0000, 1'b1, 32'hc0c0_0003},
    '{3'd1, OP_READ, 32'h0000_0058, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{3'd2, OP_FILL, 32'h0000_0300, 32'h1111_1111, 1'b0, 32'h0000_0000},
    '{3'd2, OP_FILL, 32'h0001_0300, 32'h2222_2222, 1'b0, 32'h0000_0000},
    '{3'd2, OP_READ, 32'h0000_0300, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{3'd2, OP_READ, 32'h0001_0300, 32'h0000_0000, 1'b1, 32'h2222_2222},
    '{3'd3, OP_FILL, 32'h0000_0400, 32'h4000_0000, 1'b0, 32'h0000_0000},
    '{3'd3, OP_FILL, 32'h0000_0414, 32'h4100_0001, 1'b0, 32'h0000_0000},
    '{3'd3, OP_FILL, 32'h0000_0428, 32'h4200_0002, 1'b0, 32'h0000_0000},
    '{3'd3, OP_FILL, 32'h0000_043c, 32'h4300_0003, 1'b0, 32'h0000_0000},
    '{3'd3, OP_READ, 32'h0000_0400, 32'h0000_0000, 1'b1, 32'h4000_0000},
    '{3'd3, OP_READ, 32'h0000_0414, 32'h0000_0000, 1'b1, 32'h4100_0001},
    '{3'd3, OP_READ, 32'h0000_082c, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{3'd3, OP_READ, 32'h0000_043c, 32'h0000_0000, 1'b1, 32'h4300_0003},
    '{3'd3, OP_READ, 32'h0000_0800, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{3'd3, OP_READ, 32'h0000_0428, 32'h0000_0000, 1'b1, 32'h4200_0002},
    '{3'd4, OP_READ, 32'h0000_0204, 32'h0000_0000, 1'b1, 32'hb0b0_0002},
    '{3'd4, OP_READ, 32'h0001_0301, 32'h0000_0000, 1'b1, 32'h2222_2222},
    '{3'd4, OP_READ, 32'h0000_0104, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{3'd4, OP_READ, 32'h8000_0058, 32'h0000_0000, 1'b1, 32'hc0c0_0003},
    '{3'd4, OP_READ, 32'h0000_0101, 32'h0000_0000, 1'b1, 32'ha0a0_0001},
    '{3'd4, OP_READ, 32'h0000_0414, 32'h0000_0000, 1'b1, 32'h4100_0001},
    '{3'd5, OP_RST,  32'h0000_0000, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{3'd5, OP_READ, 32'h0000_0100, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{3'd5, OP_READ, 32'h0000_0204, 32'h0000_0000, 1'b0, 32'h0000_0000},
    '{3'd5, OP_READ, 32'h0000_043c, 32'h0000_0000, 1'b0, 32'h0000_0000}
  };

  string names [NUM_TESTS] = '{"cold_miss", "fill_hit", "conflict_evict",
                               "bank_order", "back_pressure", "reset_clears"};

  logic        clk = 1'b0;
  logic        rst;
  logic        req_valid;
  addr_t       req_addr;
  logic        req_ready;
  logic        fill_valid;
  addr_t       fill_addr;
  word_t       fill_data;
  logic        rsp_valid;
  logic        rsp_hit;
  word_t       rsp_data;
  logic        rsp_ready;
  logic [31:0] lfsr_state = 32'h2aed;
  int          exp_q [$];
  int          test_checks [NUM_TESTS];
  int          test_errors [NUM_TESTS];
  int          read_count = 0;
  int          rsp_count  = 0;
  int          stray      = 0;

  cache_top u_cache_top (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_ready (req_ready),
    .fill_valid(fill_valid),
    .fill_addr (fill_addr),
    .fill_data (fill_data),
    .rsp_valid (rsp_valid),
    .rsp_hit   (rsp_hit),
    .rsp_data  (rsp_data),
    .rsp_ready (rsp_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
  endfunction

  // Two bits per cycle, low only when both are set.
  always @(posedge clk) begin
    logic b0;
    lfsr_state = lfsr_step(lfsr_state);
    b0 = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
    rsp_ready <= !(b0 && lfsr_state[0]);
  end

  task automatic check_rsp(input int idx);
    entry_t e;
    e = STIM[idx];
    test_checks[e.test]++;
    assert (rsp_hit == e.hit && (!e.hit || rsp_data == e.data)) else begin
      $display("Mismatch %s: expected hit=%0b data=%h, actual hit=%0b data=%h",
               names[e.test], e.hit, e.data, rsp_hit, rsp_data);
      test_errors[e.test]++;
    end
  endtask

  // Outputs are settled at the falling edge; transfer lands on the next rise.
  always @(negedge clk) begin
    if (!rst && rsp_valid && rsp_ready) begin
      rsp_count++;
      assert (exp_q.size() != 0) else begin
        $display("Response arrived with no read outstanding");
        stray++;
      end
      if (exp_q.size() != 0) begin
        check_rsp(exp_q.pop_front());
      end
    end
  end

  task automatic write_fill(input entry_t e);
    req_valid  <= 1'b0;
    fill_valid <= 1'b1;
    fill_addr  <= e.addr;
    fill_data  <= e.fill;
    @(posedge clk);
  endtask

  task automatic send_read(input int idx);
    fill_valid <= 1'b0;
    req_valid  <= 1'b1;
    req_addr   <= STIM[idx].addr;
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    exp_q.push_back(idx);
    read_count++;
  endtask

  task automatic apply_reset();
    req_valid  <= 1'b0;
    fill_valid <= 1'b0;
    rst        <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic finish_test(input int t);
    req_valid  <= 1'b0;
    fill_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    $display("%s: %0d checks, %0d errors", names[t], test_checks[t], test_errors[t]);
  endtask

  initial begin
    int i;
    int t;
    int total_err;
    int total_chk;
    rst        = 1'b1;
    req_valid  = 1'b0;
    req_addr   = '0;
    fill_valid = 1'b0;
    fill_addr  = '0;
    fill_data  = '0;
    rsp_ready  = 1'b0;
    for (t = 0; t < NUM_TESTS; t++) begin
      test_checks[t] = 0;
      test_errors[t] = 0;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (i = 0; i < NUM_ENTRIES; i++) begin
      case (STIM[i].op)
        OP_FILL: write_fill(STIM[i]);
        OP_READ: send_read(i);
        default: apply_reset();
      endcase
      if (i == NUM_ENTRIES - 1 || STIM[i + 1].test != STIM[i].test) begin
        finish_test(int'(STIM[i].test));
      end
    end
    total_err = stray;
    total_chk = 0;
    for (t = 0; t < NUM_TESTS; t++) begin
      total_err += test_errors[t];
      total_chk += test_checks[t];
    end
    assert (rsp_count == read_count) else begin
      $display("Got %0d responses for %0d reads", rsp_count, read_count);
      total_err++;
    end
    $display("Total: %0d checks, %0d errors", total_chk, total_err);
    if (total_err == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_ENTRIES * 20 * CLK_PERIOD);
    $display("Timeout: the run did not finish in the allowed time");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* all.f */
hdl/mem_pkg.sv
hdl/cache_pkg.sv
hdl/bank_if.sv
hdl/bram.sv
hdl/direct_map.sv
hdl/bank_router.sv
hdl/rsp_collector.sv
hdl/cache_top.sv
test/tb_cache_top.sv

/* Makefile */
sim:
	verilator --binary --timing --assert -f all.f --top-module tb_cache_top
	out=$$(./obj_dir/Vtb_cache_top); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
